// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  corePkg::aluOp op,
    input  isaPkg::word a,
    input  isaPkg::word b,
    output isaPkg::word result,
    output logic zero
);

    always_comb begin
        case (op)
            corePkg::aluAdd:  result = a + b;
            corePkg::aluSub:  result = a - b;
            corePkg::aluAnd:  result = a & b;
            corePkg::aluOr:   result = a | b;
            corePkg::aluXor:  result = a ^ b;
            corePkg::aluSlt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            corePkg::aluSltu: begin
                result = {31'b0, a < b};
            end
            corePkg::aluLui:  result = {b[15:0], 16'b0};
            default:          result = '0;
        endcase
    end

    // BEQ/BNE run as a subtract and look at this
    assign zero = (result == '0);

endmodule

// ==== hw/corePkg.sv ====
package corePkg;

    // one state per step of the multi-cycle sequence
    typedef enum logic [2:0] {
        stFetch     = 3'b000,
        stDecode    = 3'b001,
        stExecute   = 3'b010,
        stMemory    = 3'b011,
        stWriteback = 3'b100,
        stHalted    = 3'b111
    } cpuState;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSlt  = 4'd5,
        aluSltu = 4'd6,
        aluLui  = 4'd7  // b[15:0] into the upper half
    } aluOp;

    typedef struct packed {
        aluOp op;
        logic useImm;      // alu b operand is the immediate
        logic zeroExtImm;
        logic isLoad;
        logic isStore;
        logic isBeq;
        logic isBne;
        logic isJump;
        logic jumpReg;     // target comes from rs
        logic link;        // write pc + 8
        logic regWrite;
        isaPkg::regAddr destReg;
        isaPkg::word imm;  // already extended
        logic [isaPkg::jumpWidth-1:0] target;
    } decodedInstr;

    typedef struct packed {
        logic enable;
        isaPkg::regAddr addr;
        isaPkg::word data;
    } regWritePort;

endpackage

// ==== hw/cpuControl.sv ====
`timescale 1ns/1ps

module cpuControl (
    input  logic clk,
    input  logic reset,
    output logic active,
    output isaPkg::word address,
    output logic read,
    output logic write,
    input  logic waitrequest,
    output isaPkg::word writedata,
    output logic [3:0] byteenable,
    input  isaPkg::word readdata,
    output isaPkg::word instr,
    input  corePkg::decodedInstr ctrl,
    input  isaPkg::word regA,
    input  isaPkg::word regB,
    output isaPkg::word aluA,
    output isaPkg::word aluB,
    input  isaPkg::word aluResult,
    input  logic aluZero,
    output corePkg::regWritePort writePort
);

    corePkg::cpuState state;
    isaPkg::word pc;
    isaPkg::word pcPlus4;
    isaPkg::word pendingTarget;
    isaPkg::word aluOut;       // result latched at the end of execute
    logic takenNow;            // this instruction branches
    logic branchPending;       // the one before did, so we're in its delay slot
    logic memAccess;
    logic haltFetch;

    assign pcPlus4 = pc + 32'd4;
    assign memAccess = ctrl.isLoad | ctrl.isStore;
    assign haltFetch = (pc == isaPkg::haltAddress);

    assign aluA = regA;
    assign aluB = ctrl.useImm ? ctrl.imm : regB;

    // bus side, all derived from registered state so it holds under waitrequest
    assign read = (state == corePkg::stFetch && !haltFetch)
                | (state == corePkg::stMemory && ctrl.isLoad);
    assign write = (state == corePkg::stMemory) && ctrl.isStore;
    assign address = (state == corePkg::stFetch) ? pc : {aluOut[31:2], 2'b00};
    assign writedata = regB;
    assign byteenable = 4'b1111;
    assign active = (state != corePkg::stHalted);

    always_comb begin
        writePort.enable = (state == corePkg::stWriteback) && ctrl.regWrite;
        writePort.addr = ctrl.destReg;
        if (ctrl.isLoad) begin
            writePort.data = readdata;  // valid the cycle after the accepted read
        end else if (ctrl.link) begin
            writePort.data = pc + 32'd8;
        end else begin
            writePort.data = aluOut;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= corePkg::stFetch;
            pc <= isaPkg::resetVector;
            takenNow <= 1'b0;
            branchPending <= 1'b0;
        end else begin
            case (state)
                corePkg::stFetch: begin
                    if (haltFetch) begin
                        state <= corePkg::stHalted;
                    end else if (!waitrequest) begin
                        state <= corePkg::stDecode;
                    end
                end
                corePkg::stDecode: begin
                    instr <= readdata;
                    state <= corePkg::stExecute;
                end
                corePkg::stExecute: begin
                    aluOut <= aluResult;
                    if (ctrl.isJump) begin
                        takenNow <= 1'b1;
                        pendingTarget <= ctrl.jumpReg ? regA
                                                      : {pcPlus4[31:28], ctrl.target, 2'b00};
                    end else if ((ctrl.isBeq && aluZero) || (ctrl.isBne && !aluZero)) begin
                        takenNow <= 1'b1;
                        pendingTarget <= pcPlus4 + {ctrl.imm[29:0], 2'b00};
                    end
                    state <= corePkg::stMemory;
                end
                corePkg::stMemory: begin
                    if (!(memAccess && waitrequest)) begin
                        state <= corePkg::stWriteback;
                    end
                end
                corePkg::stWriteback: begin
                    pc <= branchPending ? pendingTarget : pcPlus4;
                    branchPending <= takenNow;
                    takenNow <= 1'b0;
                    state <= corePkg::stFetch;
                end
                default: state <= corePkg::stHalted; // halted is terminal
            endcase
        end
    end

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  isaPkg::word instr,
    output corePkg::decodedInstr ctrl,
    output isaPkg::regAddr srcA,
    output isaPkg::regAddr srcB
);

    isaPkg::opCode opcode;
    isaPkg::fnCode fn;
    isaPkg::regAddr rt;
    isaPkg::regAddr rd;
    logic [isaPkg::immWidth-1:0] immField;

    // field split of the R, I and J formats
    assign opcode = isaPkg::opCode'(instr[31:26]);
    assign fn = isaPkg::fnCode'(instr[5:0]);
    assign srcA = instr[25:21]; // rs
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign immField = instr[15:0];
    assign srcB = rt;

    always_comb begin
        ctrl = '0; // unknown instructions end up as a no-op
        ctrl.op = corePkg::aluAdd;
        ctrl.target = instr[isaPkg::jumpWidth-1:0];
        case (opcode)
            isaPkg::opSpecial: begin
                ctrl.destReg = rd;
                case (fn)
                    isaPkg::fnAddu: {ctrl.op, ctrl.regWrite} = {corePkg::aluAdd, 1'b1};
                    isaPkg::fnSubu: {ctrl.op, ctrl.regWrite} = {corePkg::aluSub, 1'b1};
                    isaPkg::fnAnd:  {ctrl.op, ctrl.regWrite} = {corePkg::aluAnd, 1'b1};
                    isaPkg::fnOr:   {ctrl.op, ctrl.regWrite} = {corePkg::aluOr, 1'b1};
                    isaPkg::fnXor:  {ctrl.op, ctrl.regWrite} = {corePkg::aluXor, 1'b1};
                    isaPkg::fnSlt:  {ctrl.op, ctrl.regWrite} = {corePkg::aluSlt, 1'b1};
                    isaPkg::fnSltu: {ctrl.op, ctrl.regWrite} = {corePkg::aluSltu, 1'b1};
                    isaPkg::fnJr: begin
                        ctrl.isJump = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    isaPkg::fnJalr: begin
                        ctrl.isJump = 1'b1;
                        ctrl.jumpReg = 1'b1;
                        ctrl.link = 1'b1;
                        ctrl.regWrite = 1'b1;
                    end
                    default: ;
                endcase
            end
            isaPkg::opJ: ctrl.isJump = 1'b1;
            isaPkg::opJal: begin
                ctrl.isJump = 1'b1;
                ctrl.link = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.destReg = isaPkg::linkReg;
            end
            isaPkg::opBeq: {ctrl.op, ctrl.isBeq} = {corePkg::aluSub, 1'b1};
            isaPkg::opBne: {ctrl.op, ctrl.isBne} = {corePkg::aluSub, 1'b1};
            default: begin
                // remaining opcodes are all I-type writing rt
                ctrl.useImm = 1'b1;
                ctrl.destReg = rt;
                ctrl.regWrite = (opcode != isaPkg::opSw);
                case (opcode)
                    isaPkg::opAddiu: ctrl.op = corePkg::aluAdd;
                    isaPkg::opSlti:  ctrl.op = corePkg::aluSlt;
                    isaPkg::opSltiu: ctrl.op = corePkg::aluSltu;
                    isaPkg::opAndi:  {ctrl.op, ctrl.zeroExtImm} = {corePkg::aluAnd, 1'b1};
                    isaPkg::opOri:   {ctrl.op, ctrl.zeroExtImm} = {corePkg::aluOr, 1'b1};
                    isaPkg::opXori:  {ctrl.op, ctrl.zeroExtImm} = {corePkg::aluXor, 1'b1};
                    isaPkg::opLui:   ctrl.op = corePkg::aluLui;
                    isaPkg::opLw:    ctrl.isLoad = 1'b1;
                    isaPkg::opSw:    ctrl.isStore = 1'b1;
                    default: begin
                        ctrl.useImm = 1'b0;
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
        endcase
        ctrl.imm = ctrl.zeroExtImm ? {16'b0, immField} : {{16{immField[15]}}, immField};
    end

endmodule

// ==== hw/isaPkg.sv ====
package isaPkg;

    // basic architectural widths
    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth = 16;
    localparam int jumpWidth = 26;

    typedef logic [wordWidth-1:0] word;
    typedef logic [regAddrWidth-1:0] regAddr;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'b000000, // R-type, see fnCode
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opCode;

    // function codes for opSpecial, instr[5:0]
    typedef enum logic [5:0] {
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } fnCode;

    localparam word resetVector = 32'hBFC00000;
    localparam word haltAddress = 32'h00000000; // fetch from here stops the core

    localparam regAddr linkReg = 5'd31;   // $ra
    localparam regAddr resultReg = 5'd2;  // $v0

endpackage

// ==== hw/mipsCpuBus.sv ====
`timescale 1ns/1ps

module mipsCpuBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output isaPkg::word registerV0,
    output isaPkg::word address,
    output logic write,
    output logic read,
    input  logic waitrequest,
    output isaPkg::word writedata,
    output logic [3:0] byteenable,
    input  isaPkg::word readdata
);

    isaPkg::word instr;
    corePkg::decodedInstr ctrl;
    isaPkg::regAddr srcA;
    isaPkg::regAddr srcB;
    isaPkg::word regA;
    isaPkg::word regB;
    isaPkg::word aluA;
    isaPkg::word aluB;
    isaPkg::word aluResult;
    logic aluZero;
    corePkg::regWritePort writePort;

    instrDecoder i_instrDecoder (.instr(instr), .ctrl(ctrl), .srcA(srcA), .srcB(srcB));

    regFile i_regFile (
        .clk(clk), .reset(reset), .writePort(writePort),
        .readAddrA(srcA), .readAddrB(srcB),
        .readDataA(regA), .readDataB(regB), .registerV0(registerV0)
    );

    alu i_alu (.op(ctrl.op), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero));

    cpuControl i_cpuControl (
        .clk(clk), .reset(reset), .active(active),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .instr(instr), .ctrl(ctrl), .regA(regA), .regB(regB),
        .aluA(aluA), .aluB(aluB), .aluResult(aluResult), .aluZero(aluZero),
        .writePort(writePort)
    );

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  corePkg::regWritePort writePort,
    input  isaPkg::regAddr readAddrA,
    input  isaPkg::regAddr readAddrB,
    output isaPkg::word readDataA,
    output isaPkg::word readDataB,
    output isaPkg::word registerV0
);

    isaPkg::word regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writePort.enable && writePort.addr != '0) begin // $zero stays zero
            regs[writePort.addr] <= writePort.data;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
    assign registerV0 = regs[isaPkg::resultReg]; // observation only

endmodule

// ==== mipsCpuBus.f ====
hw/isaPkg.sv
hw/corePkg.sv
hw/regFile.sv
hw/alu.sv
hw/instrDecoder.sv
hw/cpuControl.sv
hw/mipsCpuBus.sv
tests/clockGen.sv
tests/mipsCpuBusTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench, then look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f mipsCpuBus.f --top-module mipsCpuBusTb
if ./obj_dir/VmipsCpuBusTb | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

// ==== tests/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== tests/mipsCpuBusTb.sv ====
`timescale 1ns/1ps

module mipsCpuBusTb;

    localparam isaPkg::word dataBase = 32'h00001000; // held in r16
    localparam logic [15:0] markerOff = 16'h0800;    // stores here must never happen

    logic clk;
    logic reset;
    logic active;
    isaPkg::word registerV0;
    isaPkg::word address;
    logic write;
    logic read;
    logic waitrequest;
    isaPkg::word writedata;
    logic [3:0] byteenable;
    isaPkg::word readdata;

    isaPkg::word mem [isaPkg::word];      // program and data
    isaPkg::word expected [isaPkg::word]; // store address to value
    bit storeSeen [isaPkg::word];
    isaPkg::word pcBuild;
    isaPkg::word lastV0;
    isaPkg::word delaySlots;
    logic [15:0] nextOff;
    int progLen;
    bit built;
    bit firstDone;
    bit heldPrev;
    logic prevRead;
    logic prevWrite;
    isaPkg::word prevAddr;
    isaPkg::word prevData;

    clockGen i_clockGen (.clk(clk), .reset(reset));

    mipsCpuBus i_mipsCpuBus (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    task automatic stopWithFailure(input string msg, input bit wrongValue);
        if (wrongValue) begin
            $display("** Error at %0d ns: %s", $time, msg);
        end else begin
            $display("%s", msg);
        end
        $display("STATUS: FAIL");
        $fatal(1, "%s", msg);
    endtask

    function automatic isaPkg::word encR(isaPkg::regAddr rs, rt, rd, isaPkg::fnCode fn);
        return {isaPkg::opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic isaPkg::word encI(isaPkg::opCode op, isaPkg::regAddr rs, rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic isaPkg::word encJ(isaPkg::opCode op, isaPkg::word dest);
        return {op, dest[27:2]};
    endfunction

    function automatic logic [15:0] branchOff(isaPkg::word from, isaPkg::word to);
        isaPkg::word d;
        d = (to - from - 32'd4) >> 2; // relative to the delay slot
        return d[15:0];
    endfunction

    // signed order is unsigned order with the sign bits flipped
    function automatic logic lessSigned(isaPkg::word x, isaPkg::word y);
        return (x ^ 32'h80000000) < (y ^ 32'h80000000);
    endfunction

    function automatic isaPkg::word fill(isaPkg::word a);
        return {a[15:0], ~a[31:16]} ^ 32'h5a5aa5a5;
    endfunction

    task automatic emit(input isaPkg::word w);
        mem[pcBuild] = w;
        pcBuild += 32'd4;
        progLen++;
    endtask

    task automatic loadWord(input isaPkg::regAddr r, input isaPkg::word v);
        emit(encI(isaPkg::opLui, 5'd0, r, v[31:16]));
        emit(encI(isaPkg::opOri, r, r, v[15:0]));
    endtask

    task automatic storeReg(input isaPkg::regAddr r, input isaPkg::word v);
        emit(encI(isaPkg::opSw, 5'd16, r, nextOff));
        expected[dataBase + {16'h0, nextOff}] = v;
        nextOff += 16'd4;
    endtask

    task automatic runAndStore(input isaPkg::word w, input isaPkg::word result);
        emit(w); // result lands in r10
        storeReg(5'd10, result);
    endtask

    task automatic slotAndMarker(input bit marker);
        emit(encI(isaPkg::opAddiu, 5'd12, 5'd12, 16'd1)); // delay slot counts itself
        delaySlots += 32'd1;
        if (marker) begin
            emit(encI(isaPkg::opSw, 5'd16, 5'd13, markerOff));
        end
    endtask

    task automatic buildProgram();
        isaPkg::word a;
        isaPkg::word b;
        isaPkg::word sext;
        isaPkg::word zext;
        isaPkg::word at;
        logic [15:0] imm;
        logic [15:0] firstOff;
        pcBuild = isaPkg::resetVector;
        emit(encI(isaPkg::opOri, 5'd0, 5'd16, dataBase[15:0]));
        emit(encI(isaPkg::opOri, 5'd0, 5'd13, 16'd1));
        for (int round = 0; round < 3; round++) begin
            a = $urandom;
            b = $urandom;
            imm = 16'($urandom);
            if (round == 1) begin
                a[31] = ~b[31]; // signed and unsigned compares disagree
            end
            sext = {{16{imm[15]}}, imm};
            zext = {16'h0, imm};
            loadWord(5'd8, a);
            loadWord(5'd9, b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnAddu), a + b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnSubu), a - b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnAnd), a & b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnOr), a | b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnXor), a ^ b);
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnSlt), {31'd0, lessSigned(a, b)});
            runAndStore(encR(5'd8, 5'd9, 5'd10, isaPkg::fnSltu), {31'd0, a < b});
            runAndStore(encI(isaPkg::opAddiu, 5'd8, 5'd10, imm), a + sext);
            runAndStore(encI(isaPkg::opAndi, 5'd8, 5'd10, imm), a & zext);
            runAndStore(encI(isaPkg::opOri, 5'd8, 5'd10, imm), a | zext);
            runAndStore(encI(isaPkg::opXori, 5'd8, 5'd10, imm), a ^ zext);
            runAndStore(encI(isaPkg::opSlti, 5'd8, 5'd10, imm), {31'd0, lessSigned(a, sext)});
            runAndStore(encI(isaPkg::opSltiu, 5'd8, 5'd10, imm), {31'd0, a < sext});
            runAndStore(encI(isaPkg::opLui, 5'd0, 5'd10, imm), {imm, 16'h0});
        end
        // store a random word, load it back and store it again
        a = $urandom;
        loadWord(5'd11, a);
        firstOff = nextOff;
        storeReg(5'd11, a);
        emit(encI(isaPkg::opLw, 5'd16, 5'd17, firstOff));
        storeReg(5'd17, a);
        // taken BEQ, taken BNE, then a BEQ that falls through
        emit(encI(isaPkg::opBeq, 5'd13, 5'd13, branchOff(pcBuild, pcBuild + 32'd12)));
        slotAndMarker(1'b1);
        emit(encI(isaPkg::opBne, 5'd13, 5'd0, branchOff(pcBuild, pcBuild + 32'd12)));
        slotAndMarker(1'b1);
        emit(encI(isaPkg::opBeq, 5'd13, 5'd0, branchOff(pcBuild, pcBuild + 32'd12)));
        slotAndMarker(1'b0);
        storeReg(5'd13, 32'd1);
        emit(encJ(isaPkg::opJ, pcBuild + 32'd12));
        slotAndMarker(1'b1);
        at = pcBuild;
        emit(encJ(isaPkg::opJal, at + 32'd12));
        slotAndMarker(1'b1);
        storeReg(isaPkg::linkReg, at + 32'd8);
        at = pcBuild + 32'd8; // JALR sits after the two target loads
        loadWord(5'd15, at + 32'd12);
        emit(encR(5'd15, 5'd0, 5'd14, isaPkg::fnJalr));
        slotAndMarker(1'b1);
        storeReg(5'd14, at + 32'd8);
        storeReg(5'd12, delaySlots);
        // JR $zero halts once its delay slot has set v0
        imm = 16'($urandom) | 16'h0001; // nonzero so the write is visible
        lastV0 = {16'h0, imm};
        emit(encR(5'd0, 5'd0, 5'd0, isaPkg::fnJr));
        emit(encI(isaPkg::opOri, 5'd0, isaPkg::resultReg, imm));
    endtask

    // memory model with random wait states
    always @(posedge clk) begin
        isaPkg::word nextData;
        nextData = readdata;
        if (!reset && write && !waitrequest) begin
            mem[address] = writedata;
        end
        if (!reset && read && !waitrequest) begin
            nextData = mem.exists(address) ? mem[address] : fill(address);
        end
        #1;
        readdata = nextData;
        waitrequest = ($urandom % 4 == 0);
    end

    // bus checks
    always @(posedge clk) begin
        if (!reset) begin
            assert (!(read && write)) else stopWithFailure("read and write both high", 1'b0);
            if (read || write) begin
                assert (byteenable == 4'hF && address[1:0] == 2'b00)
                else stopWithFailure($sformatf("byteenable %h address %h", byteenable,
                                               address), 1'b1);
            end
            if (!firstDone && (read || write)) begin
                firstDone = 1'b1;
                assert (read && !write && active && address == isaPkg::resetVector)
                else stopWithFailure($sformatf("first access at %h", address), 1'b1);
            end
            if (heldPrev) begin
                assert (read == prevRead && write == prevWrite && address == prevAddr
                        && (!write || writedata == prevData))
                else stopWithFailure("bus request changed while waitrequest high", 1'b1);
            end
            if (write && !waitrequest) begin
                assert (expected.exists(address))
                else stopWithFailure($sformatf("unexpected store to %h", address), 1'b0);
                assert (writedata == expected[address])
                else stopWithFailure($sformatf("store to %h: got %h, expected %h", address,
                                               writedata, expected[address]), 1'b1);
                storeSeen[address] = 1'b1;
            end
            if (!active) begin
                assert (!read && !write) else stopWithFailure("bus access after halt", 1'b0);
            end
            heldPrev = waitrequest && (read || write);
            prevRead = read;
            prevWrite = write;
            prevAddr = address;
            prevData = writedata;
        end
    end

    initial begin
        void'($urandom(32'h9be56718));
        waitrequest = 1'b0;
        readdata = '0;
        nextOff = 16'd0;
        delaySlots = '0;
        buildProgram();
        built = 1'b1;
        wait (active === 1'b0);
        repeat (20) @(posedge clk);
        foreach (expected[a]) begin
            assert (storeSeen.exists(a))
            else stopWithFailure($sformatf("store to %h never happened", a), 1'b0);
        end
        assert (registerV0 == lastV0)
        else stopWithFailure($sformatf("registerV0 %h, expected %h", registerV0, lastV0), 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        wait (built);
        repeat (progLen * 40) @(posedge clk);
        stopWithFailure("timeout: the core did not halt in time", 1'b0);
    end

endmodule
